//--- Makefile
VERILATOR ?= verilator
TOP       ?= exec_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- list.f
logic/exec_pkg.sv
logic/exec_latch.sv
logic/exec_decode.sv
logic/exec_alu.sv
logic/exec_branch.sv
logic/exec_agen.sv
logic/exec_stage.sv
sim/exec_checker.sv
sim/exec_tb.sv

//--- logic/exec_agen.sv
`timescale 1ns/1ps

module exec_agen import exec_pkg::*; (
    input  exec_req_t  cur,
    input  exec_ctrl_t ctrl,
    output mem_rd_t    mem_rd,
    output mem_wr_t    mem_wr
);

    word_t addr;
    strb_t strb;

    assign addr = cur.rs1_data + sext12(cur.imm);

    always_comb begin
        case (ctrl.mem_size)
            MEM_BYTE: strb = 4'b0001;
            MEM_HALF: strb = 4'b0011;
            MEM_WORD: strb = 4'b1111;
            default:  strb = 4'b0000;
        endcase
    end

    always_comb begin
        mem_rd = '0;
        if (ctrl.is_load) begin
            mem_rd.valid     = 1'b1;
            mem_rd.rd        = cur.rd;      // load target rides with the request
            mem_rd.addr      = addr;
            mem_rd.strb      = strb;
            mem_rd.is_signed = ctrl.mem_signed;
        end
    end

    always_comb begin
        mem_wr = '0;
        if (ctrl.is_store) begin
            mem_wr.valid = 1'b1;
            mem_wr.addr  = addr;
            mem_wr.strb  = strb;
            mem_wr.data  = cur.rs2_data;
        end
    end

endmodule

//--- logic/exec_alu.sv
`timescale 1ns/1ps

module exec_alu import exec_pkg::*; (
    input  exec_req_t  cur,
    input  exec_ctrl_t ctrl,
    output wb_t        wb
);

    word_t      op_b;
    logic [4:0] shamt;
    word_t      upper;
    word_t      result;

    assign op_b  = ctrl.use_imm ? sext12(cur.imm) : cur.rs2_data;
    assign shamt = op_b[4:0];
    assign upper = {cur.imm[31:12], 12'b0};     // u-type immediate

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:   result = cur.rs1_data + op_b;
            ALU_SUB:   result = cur.rs1_data - op_b;
            ALU_AND:   result = cur.rs1_data & op_b;
            ALU_OR:    result = cur.rs1_data | op_b;
            ALU_XOR:   result = cur.rs1_data ^ op_b;
            ALU_SLL:   result = cur.rs1_data << shamt;
            ALU_SRL:   result = cur.rs1_data >> shamt;
            ALU_SRA:   result = $signed(cur.rs1_data) >>> shamt;
            ALU_SLT:   result = word_t'($signed(cur.rs1_data) < $signed(op_b));
            ALU_SLTU:  result = word_t'(cur.rs1_data < op_b);
            ALU_LUI:   result = upper;
            ALU_AUIPC: result = cur.pc + upper;
            ALU_LINK:  result = cur.pc + 32'd4;   // return address
            ALU_NONE:  result = '0;
            default:   result = '0;
        endcase
    end

    always_comb begin
        if (ctrl.alu_op == ALU_NONE) begin
            wb = '0;
        end else begin
            wb.rd   = cur.rd;
            wb.data = result;
        end
    end

endmodule

//--- logic/exec_branch.sv
`timescale 1ns/1ps

module exec_branch import exec_pkg::*; (
    input  exec_req_t  cur,
    input  exec_ctrl_t ctrl,
    output jump_t      jump
);

    logic  eq;
    logic  lt_s;
    logic  lt_u;
    word_t pc_target;
    word_t reg_target;

    assign eq   = cur.rs1_data == cur.rs2_data;
    assign lt_s = $signed(cur.rs1_data) < $signed(cur.rs2_data);
    assign lt_u = cur.rs1_data < cur.rs2_data;

    assign pc_target  = cur.pc + sext13(cur.imm);
    assign reg_target = (cur.rs1_data + sext12(cur.imm)) & ~word_t'(1);  // jalr drops bit 0

    always_comb begin
        jump.taken  = 1'b0;
        jump.target = pc_target;
        case (ctrl.br_cond)
            BR_EQ:   jump.taken = eq;
            BR_NE:   jump.taken = !eq;
            BR_LT:   jump.taken = lt_s;
            BR_GE:   jump.taken = !lt_s;
            BR_LTU:  jump.taken = lt_u;
            BR_GEU:  jump.taken = !lt_u;
            BR_JAL:  jump.taken = 1'b1;
            BR_JALR: begin
                jump.taken  = 1'b1;
                jump.target = reg_target;
            end
            default: jump.target = '0;  // not a branch
        endcase
    end

endmodule

//--- logic/exec_decode.sv
`timescale 1ns/1ps

module exec_decode import exec_pkg::*; (
    input  exec_req_t  cur,
    output exec_ctrl_t ctrl
);

    always_comb begin
        ctrl = '{alu_op: ALU_NONE, use_imm: 1'b0, br_cond: BR_NONE, is_load: 1'b0,
                 is_store: 1'b0, mem_size: MEM_BYTE, mem_signed: 1'b0};
        case (cur.opcode)
            OP_REG: begin
                case ({cur.funct7, cur.funct3})
                    {F7_BASE, F3_ADD}:  ctrl.alu_op = ALU_ADD;
                    {F7_ALT,  F3_ADD}:  ctrl.alu_op = ALU_SUB;
                    {F7_BASE, F3_AND}:  ctrl.alu_op = ALU_AND;
                    {F7_BASE, F3_OR}:   ctrl.alu_op = ALU_OR;
                    {F7_BASE, F3_XOR}:  ctrl.alu_op = ALU_XOR;
                    {F7_BASE, F3_SLL}:  ctrl.alu_op = ALU_SLL;
                    {F7_BASE, F3_SR}:   ctrl.alu_op = ALU_SRL;
                    {F7_ALT,  F3_SR}:   ctrl.alu_op = ALU_SRA;
                    {F7_BASE, F3_SLT}:  ctrl.alu_op = ALU_SLT;
                    {F7_BASE, F3_SLTU}: ctrl.alu_op = ALU_SLTU;
                    default: ;
                endcase
            end
            OP_IMM: begin
                ctrl.use_imm = 1'b1;
                case (cur.funct3)
                    F3_ADD:  ctrl.alu_op = ALU_ADD;
                    F3_AND:  ctrl.alu_op = ALU_AND;
                    F3_OR:   ctrl.alu_op = ALU_OR;
                    F3_XOR:  ctrl.alu_op = ALU_XOR;
                    F3_SLT:  ctrl.alu_op = ALU_SLT;
                    F3_SLTU: ctrl.alu_op = ALU_SLTU;
                    F3_SLL: begin
                        if (cur.funct7 == F7_BASE) ctrl.alu_op = ALU_SLL;
                    end
                    F3_SR: begin
                        if (cur.funct7 == F7_BASE) begin
                            ctrl.alu_op = ALU_SRL;
                        end else if (cur.funct7 == F7_ALT) begin
                            ctrl.alu_op = ALU_SRA;
                        end
                    end
                    default: ;
                endcase
            end
            OP_LUI:   ctrl.alu_op = ALU_LUI;
            OP_AUIPC: ctrl.alu_op = ALU_AUIPC;
            OP_JAL: begin
                ctrl.alu_op  = ALU_LINK;
                ctrl.br_cond = BR_JAL;
            end
            OP_JALR: begin
                if (cur.funct3 == F3_JALR) begin
                    ctrl.alu_op  = ALU_LINK;
                    ctrl.br_cond = BR_JALR;
                end
            end
            OP_BRANCH: begin
                case (cur.funct3)
                    F3_BEQ:  ctrl.br_cond = BR_EQ;
                    F3_BNE:  ctrl.br_cond = BR_NE;
                    F3_BLT:  ctrl.br_cond = BR_LT;
                    F3_BGE:  ctrl.br_cond = BR_GE;
                    F3_BLTU: ctrl.br_cond = BR_LTU;
                    F3_BGEU: ctrl.br_cond = BR_GEU;
                    default: ;
                endcase
            end
            OP_LOAD: begin
                ctrl.is_load = 1'b1;
                case (cur.funct3)
                    F3_MEM_B: begin
                        ctrl.mem_size   = MEM_BYTE;
                        ctrl.mem_signed = 1'b1;
                    end
                    F3_MEM_H: begin
                        ctrl.mem_size   = MEM_HALF;
                        ctrl.mem_signed = 1'b1;
                    end
                    F3_MEM_W:  ctrl.mem_size = MEM_WORD;    // no extension needed
                    F3_MEM_BU: ctrl.mem_size = MEM_BYTE;
                    F3_MEM_HU: ctrl.mem_size = MEM_HALF;
                    default:   ctrl.is_load = 1'b0;
                endcase
            end
            OP_STORE: begin
                ctrl.is_store = 1'b1;
                case (cur.funct3)
                    F3_MEM_B: ctrl.mem_size = MEM_BYTE;
                    F3_MEM_H: ctrl.mem_size = MEM_HALF;
                    F3_MEM_W: ctrl.mem_size = MEM_WORD;
                    default:  ctrl.is_store = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

endmodule

//--- logic/exec_latch.sv
`timescale 1ns/1ps

module exec_latch import exec_pkg::*; (
    input  logic      CLK,
    input  logic      rst_n,
    input  logic      flush,
    input  logic      stall,
    input  logic      mem_wait,
    input  exec_req_t req,
    output exec_req_t cur
);

    exec_req_t held;

    always_ff @(posedge CLK) begin
        if (!rst_n || flush || stall) begin
            held <= '0;             // bubble decodes to nothing
        end else if (!mem_wait) begin
            held <= req;
        end
    end

    assign cur = held;

endmodule

//--- logic/exec_pkg.sv
package exec_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [3:0]      strb_t;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;    // sub, sra, srai

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;    // srl or sra by funct7
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_MEM_B  = 3'b000;  // lb, sb
    localparam logic [2:0] F3_MEM_H  = 3'b001;  // lh, sh
    localparam logic [2:0] F3_MEM_W  = 3'b010;  // lw, sw
    localparam logic [2:0] F3_MEM_BU = 3'b100;
    localparam logic [2:0] F3_MEM_HU = 3'b101;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL,
        ALU_SRA, ALU_SLT, ALU_SLTU, ALU_LUI, ALU_AUIPC, ALU_LINK, ALU_NONE
    } alu_op_e;

    // eight conditions plus none
    typedef enum logic [3:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR, BR_NONE
    } br_cond_e;

    typedef enum logic [1:0] {
        MEM_BYTE, MEM_HALF, MEM_WORD
    } mem_size_e;

    typedef struct packed {
        word_t      pc;
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        word_t      rs1_data;
        reg_addr_t  rs2;
        word_t      rs2_data;
        word_t      imm;
    } exec_req_t;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      use_imm;
        br_cond_e  br_cond;
        logic      is_load;
        logic      is_store;
        mem_size_e mem_size;
        logic      mem_signed;
    } exec_ctrl_t;

    typedef struct packed {
        reg_addr_t rd;      // 0 means no write
        word_t     data;
    } wb_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     addr;
        strb_t     strb;
        logic      is_signed;
    } mem_rd_t;

    typedef struct packed {
        logic  valid;
        word_t addr;
        strb_t strb;
        word_t data;
    } mem_wr_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } jump_t;

    function automatic word_t sext12(input word_t imm);
        return {{(XLEN-12){imm[11]}}, imm[11:0]};
    endfunction

    function automatic word_t sext13(input word_t imm);
        return {{(XLEN-13){imm[12]}}, imm[12:1], 1'b0};   // bit 0 always clear
    endfunction

endpackage

//--- logic/exec_stage.sv
`timescale 1ns/1ps

module exec_stage import exec_pkg::*; (
    input  logic      CLK,
    input  logic      rst_n,
    input  logic      flush,
    input  logic      stall,
    input  logic      mem_wait,
    input  exec_req_t req,
    output wb_t       wb,
    output mem_rd_t   mem_rd,
    output mem_wr_t   mem_wr,
    output jump_t     jump
);

    exec_req_t  cur;    // instruction in execute
    exec_ctrl_t ctrl;

    exec_latch u_latch (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .flush    (flush),
        .stall    (stall),
        .mem_wait (mem_wait),
        .req      (req),
        .cur      (cur)
    );

    exec_decode u_decode (
        .cur  (cur),
        .ctrl (ctrl)
    );

    exec_alu u_alu (
        .cur  (cur),
        .ctrl (ctrl),
        .wb   (wb)
    );

    exec_branch u_branch (
        .cur  (cur),
        .ctrl (ctrl),
        .jump (jump)
    );

    exec_agen u_agen (
        .cur    (cur),
        .ctrl   (ctrl),
        .mem_rd (mem_rd),
        .mem_wr (mem_wr)
    );

endmodule

//--- sim/exec_checker.sv
`timescale 1ns/1ps

module exec_checker import exec_pkg::*; (
    input logic    CLK,
    input logic    rst_n,
    input logic    flush,
    input logic    stall,
    input logic    mem_wait,
    input wb_t     wb,
    input mem_rd_t mem_rd,
    input mem_wr_t mem_wr,
    input jump_t   jump
);

    logic hold;

    assign hold = rst_n && !flush && !stall && mem_wait;   // latch keeps its contents

    one_request: assert property (@(posedge CLK) disable iff (!rst_n)
        !(mem_rd.valid && mem_wr.valid))
        else $error("load and store requests raised in the same cycle");

    target_aligned: assert property (@(posedge CLK) disable iff (!rst_n)
        jump.taken |-> !jump.target[0])
        else $error("jump target has bit 0 set");

    outputs_held: assert property (@(posedge CLK)
        $past(hold) |-> $stable(wb) && $stable(mem_rd) && $stable(mem_wr) && $stable(jump))
        else $error("outputs changed while mem_wait held the stage");

endmodule

bind exec_stage exec_checker u_checker (.*);

//--- sim/exec_tb.sv
`timescale 1ns/1ps

module exec_tb import exec_pkg::*; ();

    localparam int    NUM_TESTS  = 3000;
    localparam int    TIMEOUT_NS = NUM_TESTS * 10 + 200;
    localparam word_t SEED       = 32'h9ca7b954;

    typedef struct packed {
        wb_t     wb;
        mem_rd_t mem_rd;
        mem_wr_t mem_wr;
        jump_t   jump;
    } out_t;

    logic      CLK;
    logic      rst_n;
    logic      flush;
    logic      stall;
    logic      mem_wait;
    exec_req_t req;
    wb_t       wb;
    mem_rd_t   mem_rd;
    mem_wr_t   mem_wr;
    jump_t     jump;

    exec_req_t model_cur;   // what the latch should hold
    string     req_name;
    string     model_name;
    out_t      exp;

    exec_stage dut (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .flush    (flush),
        .stall    (stall),
        .mem_wait (mem_wait),
        .req      (req),
        .wb       (wb),
        .mem_rd   (mem_rd),
        .mem_wr   (mem_wr),
        .jump     (jump)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic strb_t strobes(input logic [1:0] size);
        return (size == 2'd0) ? 4'b0001 : (size == 2'd1) ? 4'b0011 : 4'b1111;
    endfunction

    function automatic out_t exec_ref(input exec_req_t r);
        out_t  o;
        word_t i12;
        word_t i13;
        word_t upper;
        word_t opb;
        word_t res;
        logic  ok;
        logic  alt;
        o     = '0;
        i12   = {{20{r.imm[11]}}, r.imm[11:0]};
        i13   = {{19{r.imm[12]}}, r.imm[12:1], 1'b0};
        upper = {r.imm[31:12], 12'h000};
        opb   = (r.opcode == OP_IMM) ? i12 : r.rs2_data;
        alt   = (r.funct7 == F7_ALT);
        ok    = 1'b1;
        case (r.opcode)
            OP_REG, OP_IMM: begin
                if (r.opcode == OP_REG) begin
                    ok = r.funct7 == F7_BASE || (alt && (r.funct3 == 3'd0 || r.funct3 == 3'd5));
                end else begin
                    ok = (r.funct3 != 3'd1 && r.funct3 != 3'd5) || r.funct7 == F7_BASE
                         || (alt && r.funct3 == 3'd5);
                end
                case (r.funct3)
                    3'd0: res = (alt && r.opcode == OP_REG) ? r.rs1_data - opb : r.rs1_data + opb;
                    3'd1: res = r.rs1_data << opb[4:0];
                    3'd2: res = {31'b0, $signed(r.rs1_data) < $signed(opb)};
                    3'd3: res = {31'b0, r.rs1_data < opb};
                    3'd4: res = r.rs1_data ^ opb;
                    3'd5: begin
                        if (alt) res = $signed(r.rs1_data) >>> opb[4:0];
                        else res = r.rs1_data >> opb[4:0];
                    end
                    3'd6: res = r.rs1_data | opb;
                    default: res = r.rs1_data & opb;
                endcase
                if (ok) o.wb = '{rd: r.rd, data: res};
            end
            OP_LUI:   o.wb = '{rd: r.rd, data: upper};
            OP_AUIPC: o.wb = '{rd: r.rd, data: r.pc + upper};
            OP_JAL: begin
                o.wb   = '{rd: r.rd, data: r.pc + 32'd4};
                o.jump = '{taken: 1'b1, target: r.pc + i13};
            end
            OP_JALR: begin
                if (r.funct3 == 3'd0) begin
                    o.wb   = '{rd: r.rd, data: r.pc + 32'd4};
                    o.jump = '{taken: 1'b1, target: (r.rs1_data + i12) & 32'hffff_fffe};
                end
            end
            OP_BRANCH: begin
                case (r.funct3)
                    3'd0: o.jump.taken = r.rs1_data == r.rs2_data;
                    3'd1: o.jump.taken = r.rs1_data != r.rs2_data;
                    3'd4: o.jump.taken = $signed(r.rs1_data) < $signed(r.rs2_data);
                    3'd5: o.jump.taken = $signed(r.rs1_data) >= $signed(r.rs2_data);
                    3'd6: o.jump.taken = r.rs1_data < r.rs2_data;
                    3'd7: o.jump.taken = r.rs1_data >= r.rs2_data;
                    default: ok = 1'b0;
                endcase
                if (ok) o.jump.target = r.pc + i13;
            end
            OP_LOAD: begin
                if (r.funct3 != 3'd3 && r.funct3 < 3'd6) begin
                    o.mem_rd = '{valid: 1'b1, rd: r.rd, addr: r.rs1_data + i12,
                                 strb: strobes(r.funct3[1:0]),
                                 is_signed: r.funct3 == 3'd0 || r.funct3 == 3'd1};
                end
            end
            OP_STORE: begin
                if (r.funct3 < 3'd3) begin
                    o.mem_wr = '{valid: 1'b1, addr: r.rs1_data + i12,
                                 strb: strobes(r.funct3[1:0]), data: r.rs2_data};
                end
            end
            default: ;
        endcase
        return o;
    endfunction

    task automatic draw_instr(input int idx, output exec_req_t r, output string name);
        word_t rnd;
        int    kind;
        string kname;
        rnd        = $urandom;
        r.pc       = {rnd[31:2], 2'b00};
        rnd        = $urandom;
        r.rd       = rnd[4:0];
        r.rs1      = rnd[9:5];
        r.rs2      = rnd[14:10];
        r.funct3   = rnd[17:15];
        r.funct7   = rnd[18] ? F7_ALT : F7_BASE;
        r.rs1_data = $urandom;
        r.rs2_data = (rnd[19] && rnd[20]) ? r.rs1_data : $urandom;  // equal operands now and then
        r.imm      = $urandom;
        kind       = $urandom % 12;
        case (kind)
            0, 1: begin
                r.opcode = OP_REG;
                if (r.funct3 != 3'd0 && r.funct3 != 3'd5) r.funct7 = F7_BASE;
                kname = "reg_alu";
            end
            2, 3: begin
                r.opcode = OP_IMM;
                if (r.funct3 == 3'd1) r.funct7 = F7_BASE;
                kname = "imm_alu";
            end
            4: begin
                r.opcode = OP_LUI;
                kname    = "lui";
            end
            5: begin
                r.opcode = OP_AUIPC;
                kname    = "auipc";
            end
            6: begin
                r.opcode = OP_JAL;
                kname    = "jal";
            end
            7: begin
                r.opcode = OP_JALR;
                r.funct3 = 3'd0;
                kname    = "jalr";
            end
            8: begin
                r.opcode = OP_BRANCH;
                if (r.funct3 == 3'd2 || r.funct3 == 3'd3) r.funct3 = r.funct3 + 3'd4;
                kname = "branch";
            end
            9: begin
                r.opcode = OP_LOAD;
                if (r.funct3 == 3'd3 || r.funct3 >= 3'd6) r.funct3 = 3'd2;
                kname = "load";
            end
            10: begin
                r.opcode = OP_STORE;
                r.funct3 = (r.funct3[1:0] == 2'd3) ? 3'd2 : {1'b0, r.funct3[1:0]};
                kname    = "store";
            end
            default: begin
                kname = "illegal";
                if (rnd[21]) begin
                    r.opcode = rnd[27:21];  // may hit a legal one, the model copes
                end else begin
                    case (r.funct3[1:0])
                        2'd0: begin
                            if (rnd[22]) begin
                                r.opcode = OP_IMM;      // shift with a bad funct7
                                r.funct3 = rnd[23] ? 3'd1 : 3'd5;
                                r.funct7 = rnd[23] ? F7_ALT : 7'h01;
                            end else begin
                                r.opcode = OP_REG;
                                r.funct3 = rnd[25:23];
                                if (rnd[26] && r.funct3 != 3'd0 && r.funct3 != 3'd5) begin
                                    r.funct7 = F7_ALT;
                                end else begin
                                    r.funct7 = 7'h01;
                                end
                            end
                        end
                        2'd1: begin
                            r.opcode = OP_BRANCH;
                            r.funct3 = 3'd2;
                        end
                        2'd2: begin
                            r.opcode = OP_LOAD;
                            r.funct3 = 3'd7;
                        end
                        default: begin
                            r.opcode = OP_JALR;
                            r.funct3 = 3'd1;
                        end
                    endcase
                end
            end
        endcase
        name = $sformatf("%s #%0d", kname, idx);
    endtask

    task automatic check_field(input string test, input string field,
                               input logic [68:0] expv, input logic [68:0] actv);
        assert (actv === expv) else begin
            $display("Mismatch in %s, %s: expected %h actual %h", test, field, expv, actv);
            $display("Result: FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    // capture rule of the execute latch
    always @(posedge CLK) begin
        if (!rst_n || flush || stall) begin
            model_cur  <= '0;
            model_name <= "bubble";
        end else if (!mem_wait) begin
            model_cur  <= req;
            model_name <= req_name;
        end
    end

    initial begin
        @(posedge CLK);
        forever begin
            #9;             // just before the next edge
            exp = exec_ref(model_cur);
            check_field(model_name, "wb", 69'(exp.wb), 69'(wb));
            check_field(model_name, "mem_rd", 69'(exp.mem_rd), 69'(mem_rd));
            check_field(model_name, "mem_wr", 69'(exp.mem_wr), 69'(mem_wr));
            check_field(model_name, "jump", 69'(exp.jump), 69'(jump));
            @(posedge CLK);
        end
    end

    initial begin
        #TIMEOUT_NS;
        $display("Timeout: the run did not finish in time");
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(SEED));
        rst_n    = 1'b0;
        flush    = 1'b0;
        stall    = 1'b0;
        mem_wait = 1'b0;
        req      = '0;
        req_name = "idle";
        repeat (2) @(posedge CLK);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            flush    = ($urandom % 100) < 3;
            stall    = ($urandom % 100) < 3;
            mem_wait = ($urandom % 100) < 10;
            draw_instr(i, req, req_name);
            @(posedge CLK);
            #1;
        end
        flush    = 1'b0;
        stall    = 1'b0;
        mem_wait = 1'b0;
        req      = '0;
        req_name = "drain";
        repeat (2) @(posedge CLK);
        #2;
        $display("Result: PASSED");
        $finish;
    end

endmodule
